//--- Bender.yml
package:
  name: ctrlport_to_sync_io

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/sync_io_pkg.sv
      - hdl/sync_io_regs.sv
      - hdl/sync_io_sequencer.sv
      - hdl/wb_byte_writer.sv
      - hdl/ctrlport_to_sync_io.sv
  - target: test
    files:
      - tests/wb_i2c_core_model.sv
      - tests/tb_ctrlport_to_sync_io.sv

//--- hdl/ctrlport_to_sync_io.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlport_to_sync_io (
  input  logic                      ctrlport_clk,
  input  logic                      ctrlport_rst,
  // controlport slave
  input  logic                      req_wr_i,
  input  logic                      req_rd_i,
  input  sync_io_pkg::ctrl_addr_t   req_addr_i,
  input  sync_io_pkg::ctrl_data_t   req_data_i,
  output logic                      resp_ack_o,
  output sync_io_pkg::ctrl_status_t resp_status_o,
  output sync_io_pkg::ctrl_data_t   resp_data_o,
  // wishbone master to the i2c core
  output logic                      wb_cyc_o,
  output logic                      wb_we_o,
  output sync_io_pkg::wb_addr_t     wb_adr_o,
  output sync_io_pkg::wb_byte_t     wb_dat_o,
  input  logic                      wb_ack_i,
  input  sync_io_pkg::wb_byte_t     wb_dat_i
);

  // --------------------------------------------------
  // regs to sequencer
  // --------------------------------------------------
  logic                  setup_trig;
  logic                  config_trig;
  logic                  setup_busy;
  logic                  config_busy;
  sync_io_pkg::io_word_t io_word;

  // sequencer to byte writer
  logic                  core_setup_req;
  logic                  core_enabled;
  logic                  byte_req;
  logic                  byte_done;
  sync_io_pkg::wb_byte_t tx_byte;
  sync_io_pkg::wb_byte_t cmd_byte;

  sync_io_regs u_regs (
    .ctrlport_clk  (ctrlport_clk),
    .ctrlport_rst  (ctrlport_rst),
    .req_wr_i      (req_wr_i),
    .req_rd_i      (req_rd_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .setup_busy_i  (setup_busy),
    .config_busy_i (config_busy),
    .resp_ack_o    (resp_ack_o),
    .resp_status_o (resp_status_o),
    .resp_data_o   (resp_data_o),
    .setup_trig_o  (setup_trig),
    .config_trig_o (config_trig),
    .io_word_o     (io_word)
  );

  sync_io_sequencer u_seq (
    .ctrlport_clk     (ctrlport_clk),
    .ctrlport_rst     (ctrlport_rst),
    .setup_trig_i     (setup_trig),
    .config_trig_i    (config_trig),
    .io_word_i        (io_word),
    .core_enabled_i   (core_enabled),
    .byte_done_i      (byte_done),
    .setup_busy_o     (setup_busy),
    .config_busy_o    (config_busy),
    .core_setup_req_o (core_setup_req),
    .byte_req_o       (byte_req),
    .tx_byte_o        (tx_byte),
    .cmd_byte_o       (cmd_byte)
  );

  wb_byte_writer u_writer (
    .ctrlport_clk     (ctrlport_clk),
    .ctrlport_rst     (ctrlport_rst),
    .core_setup_req_i (core_setup_req),
    .byte_req_i       (byte_req),
    .tx_byte_i        (tx_byte),
    .cmd_byte_i       (cmd_byte),
    .wb_ack_i         (wb_ack_i),
    .wb_dat_i         (wb_dat_i),
    .core_enabled_o   (core_enabled),
    .byte_done_o      (byte_done),
    .wb_cyc_o         (wb_cyc_o),
    .wb_we_o          (wb_we_o),
    .wb_adr_o         (wb_adr_o),
    .wb_dat_o         (wb_dat_o)
  );

endmodule

`default_nettype wire

//--- hdl/sync_io_defs.svh
`ifndef SYNC_IO_DEFS_SVH
`define SYNC_IO_DEFS_SVH

// --------------------------------------------------
// controlport window
// --------------------------------------------------
`define SYNC_IO_BASE_ADDR 20'h00000
`define SYNC_IO_NUM_ADDR  32
// scl divider seen by the user, core runs 5 phases per scl period
`define SYNC_IO_PRESCALE  500

// register offsets from base
`define SYNC_1_REG    20'h00
`define SYNC_2_REG    20'h04
`define SYNC_3_REG    20'h08
`define SYNC_4_REG    20'h0C
`define SYNC_5_REG    20'h10
`define RFS_EN_REG    20'h14
`define SETUP_REG     20'h18
`define CONFIG_IO_REG 20'h1C

// response status codes
`define CTRL_STS_OKAY   2'b00
`define CTRL_STS_CMDERR 2'b01

// --------------------------------------------------
// wishbone i2c core registers
// --------------------------------------------------
`define WB_PRER_LO 3'd0
`define WB_PRER_HI 3'd1
`define WB_CTR     3'd2
`define WB_TXR     3'd3
// cr on write, sr on read
`define WB_CR      3'd4
`define WB_SR      3'd4

`define WB_CORE_EN 8'h80

// command register bytes
`define CR_START_AND_WRITE 8'h90
`define CR_WRITE           8'h10
`define CR_WRITE_AND_STOP  8'h50

// --------------------------------------------------
// io expander
// --------------------------------------------------
`define IO_EXP_SLAVE_ADDR       7'h20
`define IO_EXP_OUTPUT_PORT0_REG 8'h02
`define IO_EXP_CONFIG0_REG      8'h06

`endif

//--- hdl/sync_io_pkg.sv
`default_nettype none

package sync_io_pkg;

  // controlport fields
  typedef logic [19:0] ctrl_addr_t;
  typedef logic [31:0] ctrl_data_t;
  typedef logic [1:0]  ctrl_status_t;

  // one switch select
  typedef logic [2:0]  sync_sel_t;
  // rfs enable in bit 15, sync5 down to sync1 below
  typedef logic [15:0] io_word_t;

  // wishbone side of the i2c core
  typedef logic [2:0]  wb_addr_t;
  typedef logic [7:0]  wb_byte_t;

  // run level fsm
  typedef enum logic [2:0] {
    S_IDLE,
    S_EN,
    S_ADDR,
    S_REG,
    S_LO,
    S_HI
  } seq_state_e;

  // wishbone access fsm
  typedef enum logic [3:0] {
    W_IDLE,
    W_PRE_LO,
    W_PRE_HI,
    W_EN,
    W_TXR,
    W_CR,
    W_TIP_START,
    W_TIP,
    W_FIN
  } wb_state_e;

endpackage

`default_nettype wire

//--- hdl/sync_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sync_io_defs.svh"

module sync_io_regs (
  input  logic                      ctrlport_clk,
  input  logic                      ctrlport_rst,
  input  logic                      req_wr_i,
  input  logic                      req_rd_i,
  input  sync_io_pkg::ctrl_addr_t   req_addr_i,
  input  sync_io_pkg::ctrl_data_t   req_data_i,
  input  logic                      setup_busy_i,
  input  logic                      config_busy_i,
  output logic                      resp_ack_o,
  output sync_io_pkg::ctrl_status_t resp_status_o,
  output sync_io_pkg::ctrl_data_t   resp_data_o,
  output logic                      setup_trig_o,
  output logic                      config_trig_o,
  output sync_io_pkg::io_word_t     io_word_o
);

  sync_io_pkg::sync_sel_t  sync_1;
  sync_io_pkg::sync_sel_t  sync_2;
  sync_io_pkg::sync_sel_t  sync_3;
  sync_io_pkg::sync_sel_t  sync_4;
  sync_io_pkg::sync_sel_t  sync_5;
  logic                    rfs_en;

  logic                    addr_in_range;
  sync_io_pkg::ctrl_addr_t req_offset;
  logic                    read_hit;
  sync_io_pkg::ctrl_data_t read_data;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  // window is [base, base + 32)
  assign addr_in_range = (req_addr_i >= `SYNC_IO_BASE_ADDR) &&
                         (req_addr_i < (`SYNC_IO_BASE_ADDR + `SYNC_IO_NUM_ADDR));
  assign req_offset    = req_addr_i - `SYNC_IO_BASE_ADDR;

  // readback mux, unmapped offsets give zero data
  always_comb begin
    read_hit  = 1'b1;
    read_data = '0;
    case (req_offset)
      `SYNC_1_REG:    read_data[2:0] = sync_1;
      `SYNC_2_REG:    read_data[2:0] = sync_2;
      `SYNC_3_REG:    read_data[2:0] = sync_3;
      `SYNC_4_REG:    read_data[2:0] = sync_4;
      `SYNC_5_REG:    read_data[2:0] = sync_5;
      `RFS_EN_REG:    read_data[0]   = rfs_en;
      // status bits read 1 once the run is over
      `SETUP_REG:     read_data[0]   = ~setup_busy_i;
      `CONFIG_IO_REG: read_data[0]   = ~config_busy_i;
      default:        read_hit       = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // register file and response
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack_o    <= 1'b0;
      resp_status_o <= `CTRL_STS_OKAY;
      resp_data_o   <= '0;
      setup_trig_o  <= 1'b0;
      config_trig_o <= 1'b0;
      sync_1        <= '0;
      sync_2        <= '0;
      sync_3        <= '0;
      sync_4        <= '0;
      sync_5        <= '0;
      rfs_en        <= 1'b0;
    end else begin
      // one ack per in-range request, one cycle later
      resp_ack_o    <= addr_in_range && (req_wr_i || req_rd_i);
      // triggers are single cycle strobes
      setup_trig_o  <= 1'b0;
      config_trig_o <= 1'b0;

      if (req_wr_i && addr_in_range) begin
        resp_status_o <= `CTRL_STS_OKAY;
        resp_data_o   <= '0;
        case (req_offset)
          `SYNC_1_REG:    sync_1 <= req_data_i[2:0];
          `SYNC_2_REG:    sync_2 <= req_data_i[2:0];
          `SYNC_3_REG:    sync_3 <= req_data_i[2:0];
          `SYNC_4_REG:    sync_4 <= req_data_i[2:0];
          `SYNC_5_REG:    sync_5 <= req_data_i[2:0];
          `RFS_EN_REG:    rfs_en <= req_data_i[0];
          // no setup while a config run owns the bus, and vice versa
          `SETUP_REG:     setup_trig_o  <= ~config_busy_i;
          `CONFIG_IO_REG: config_trig_o <= ~setup_busy_i;
          default: ;
        endcase
      end else if (req_rd_i && addr_in_range) begin
        resp_status_o <= read_hit ? `CTRL_STS_OKAY : `CTRL_STS_CMDERR;
        resp_data_o   <= read_data;
      end
    end
  end

  // word as driven onto the expander ports
  assign io_word_o = {rfs_en, sync_5, sync_4, sync_3, sync_2, sync_1};

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // master waits for each ack, so acks never come back to back
  a_ack_single: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    resp_ack_o |=> !resp_ack_o);

endmodule

`default_nettype wire

//--- hdl/sync_io_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sync_io_defs.svh"

module sync_io_sequencer (
  input  logic                  ctrlport_clk,
  input  logic                  ctrlport_rst,
  input  logic                  setup_trig_i,
  input  logic                  config_trig_i,
  input  sync_io_pkg::io_word_t io_word_i,
  input  logic                  core_enabled_i,
  input  logic                  byte_done_i,
  output logic                  setup_busy_o,
  output logic                  config_busy_o,
  output logic                  core_setup_req_o,
  output logic                  byte_req_o,
  output sync_io_pkg::wb_byte_t tx_byte_o,
  output sync_io_pkg::wb_byte_t cmd_byte_o
);

  sync_io_pkg::seq_state_e state;
  // payload for the two data bytes, captured at run start
  sync_io_pkg::io_word_t   run_word;

  // --------------------------------------------------
  // byte and command per step
  // --------------------------------------------------
  // only changes with state, byte_req is low in that cycle
  always_comb begin
    tx_byte_o  = '0;
    cmd_byte_o = '0;
    case (state)
      sync_io_pkg::S_ADDR: begin
        // slave address plus write bit
        tx_byte_o  = {`IO_EXP_SLAVE_ADDR, 1'b0};
        cmd_byte_o = `CR_START_AND_WRITE;
      end
      sync_io_pkg::S_REG: begin
        tx_byte_o  = setup_busy_o ? `IO_EXP_CONFIG0_REG : `IO_EXP_OUTPUT_PORT0_REG;
        cmd_byte_o = `CR_WRITE;
      end
      sync_io_pkg::S_LO: begin
        tx_byte_o  = run_word[7:0];
        cmd_byte_o = `CR_WRITE;
      end
      sync_io_pkg::S_HI: begin
        tx_byte_o  = run_word[15:8];
        cmd_byte_o = `CR_WRITE_AND_STOP;
      end
      default: ;
    endcase
  end

  // --------------------------------------------------
  // run fsm
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state            <= sync_io_pkg::S_IDLE;
      setup_busy_o     <= 1'b0;
      config_busy_o    <= 1'b0;
      core_setup_req_o <= 1'b0;
      byte_req_o       <= 1'b0;
      run_word         <= '0;
    end else begin
      case (state)
        sync_io_pkg::S_IDLE: begin
          byte_req_o <= 1'b0;
          if (setup_trig_i) begin
            // zero word makes every expander pin an output
            setup_busy_o     <= 1'b1;
            core_setup_req_o <= 1'b1;
            run_word         <= '0;
            state            <= sync_io_pkg::S_EN;
          end else if (config_trig_i) begin
            config_busy_o <= 1'b1;
            run_word      <= io_word_i;
            state         <= sync_io_pkg::S_ADDR;
          end
        end
        sync_io_pkg::S_EN: begin
          // core is programmed once, later setups pass straight through
          if (core_enabled_i) begin
            core_setup_req_o <= 1'b0;
            state            <= sync_io_pkg::S_ADDR;
          end
        end
        sync_io_pkg::S_ADDR, sync_io_pkg::S_REG, sync_io_pkg::S_LO,
        sync_io_pkg::S_HI: begin
          if (byte_done_i) begin
            // drop request for a cycle so the writer can go idle
            byte_req_o <= 1'b0;
            case (state)
              sync_io_pkg::S_ADDR: state <= sync_io_pkg::S_REG;
              sync_io_pkg::S_REG:  state <= sync_io_pkg::S_LO;
              sync_io_pkg::S_LO:   state <= sync_io_pkg::S_HI;
              default: begin
                setup_busy_o  <= 1'b0;
                config_busy_o <= 1'b0;
                state         <= sync_io_pkg::S_IDLE;
              end
            endcase
          end else begin
            byte_req_o <= 1'b1;
          end
        end
        default: state <= sync_io_pkg::S_IDLE;
      endcase
    end
  end

  // writer only finishes a byte that was asked for
  a_done_in_req: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    byte_done_i |-> byte_req_o);

endmodule

`default_nettype wire

//--- hdl/wb_byte_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sync_io_defs.svh"

module wb_byte_writer (
  input  logic                  ctrlport_clk,
  input  logic                  ctrlport_rst,
  input  logic                  core_setup_req_i,
  input  logic                  byte_req_i,
  input  sync_io_pkg::wb_byte_t tx_byte_i,
  input  sync_io_pkg::wb_byte_t cmd_byte_i,
  input  logic                  wb_ack_i,
  input  sync_io_pkg::wb_byte_t wb_dat_i,
  output logic                  core_enabled_o,
  output logic                  byte_done_o,
  output logic                  wb_cyc_o,
  output logic                  wb_we_o,
  output sync_io_pkg::wb_addr_t wb_adr_o,
  output sync_io_pkg::wb_byte_t wb_dat_o
);

  // core divides by 5 internally per scl period
  localparam int unsigned PRESCALE_DIV = `SYNC_IO_PRESCALE / 5;
  localparam logic [15:0] PRER_VAL     = 16'(PRESCALE_DIV);

  if (`SYNC_IO_PRESCALE % 5 != 0) begin : g_prescale_check
    $error("sync io prescale must be divisible by 5");
  end

  sync_io_pkg::wb_state_e state;
  logic                   acc_valid;
  logic                   acc_we;
  sync_io_pkg::wb_addr_t  acc_adr;
  sync_io_pkg::wb_byte_t  acc_dat;
  logic                   acc_done;

  // --------------------------------------------------
  // access issued by each state
  // --------------------------------------------------
  always_comb begin
    acc_valid = 1'b1;
    acc_we    = 1'b1;
    acc_adr   = '0;
    acc_dat   = '0;
    case (state)
      sync_io_pkg::W_PRE_LO: begin
        acc_adr = `WB_PRER_LO;
        acc_dat = PRER_VAL[7:0];
      end
      sync_io_pkg::W_PRE_HI: begin
        acc_adr = `WB_PRER_HI;
        acc_dat = PRER_VAL[15:8];
      end
      sync_io_pkg::W_EN: begin
        acc_adr = `WB_CTR;
        acc_dat = `WB_CORE_EN;
      end
      sync_io_pkg::W_TXR: begin
        acc_adr = `WB_TXR;
        acc_dat = tx_byte_i;
      end
      sync_io_pkg::W_CR: begin
        acc_adr = `WB_CR;
        acc_dat = cmd_byte_i;
      end
      // status polls
      sync_io_pkg::W_TIP_START, sync_io_pkg::W_TIP: begin
        acc_we  = 1'b0;
        acc_adr = `WB_SR;
      end
      default: begin
        acc_valid = 1'b0;
        acc_we    = 1'b0;
      end
    endcase
  end

  assign acc_done = wb_cyc_o && wb_ack_i;

  // --------------------------------------------------
  // bus cycle and fsm
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state          <= sync_io_pkg::W_IDLE;
      wb_cyc_o       <= 1'b0;
      wb_we_o        <= 1'b0;
      wb_adr_o       <= '0;
      wb_dat_o       <= '0;
      core_enabled_o <= 1'b0;
      byte_done_o    <= 1'b0;
    end else begin
      byte_done_o <= 1'b0;

      // address and data load only while the bus is idle
      if (!wb_cyc_o) begin
        if (acc_valid) begin
          wb_cyc_o <= 1'b1;
          wb_we_o  <= acc_we;
          wb_adr_o <= acc_adr;
          wb_dat_o <= acc_dat;
        end
      end else if (wb_ack_i) begin
        wb_cyc_o <= 1'b0;
      end

      case (state)
        sync_io_pkg::W_IDLE: begin
          if (core_setup_req_i && !core_enabled_o) begin
            state <= sync_io_pkg::W_PRE_LO;
          end else if (byte_req_i) begin
            state <= sync_io_pkg::W_TXR;
          end
        end
        sync_io_pkg::W_PRE_LO: if (acc_done) state <= sync_io_pkg::W_PRE_HI;
        sync_io_pkg::W_PRE_HI: if (acc_done) state <= sync_io_pkg::W_EN;
        sync_io_pkg::W_EN: begin
          if (acc_done) begin
            core_enabled_o <= 1'b1;
            state          <= sync_io_pkg::W_IDLE;
          end
        end
        sync_io_pkg::W_TXR: if (acc_done) state <= sync_io_pkg::W_CR;
        sync_io_pkg::W_CR:  if (acc_done) state <= sync_io_pkg::W_TIP_START;
        // wait for tip to rise, then to fall
        sync_io_pkg::W_TIP_START: begin
          if (acc_done && wb_dat_i[1]) begin
            state <= sync_io_pkg::W_TIP;
          end
        end
        sync_io_pkg::W_TIP: begin
          if (acc_done && !wb_dat_i[1]) begin
            byte_done_o <= 1'b1;
            state       <= sync_io_pkg::W_FIN;
          end
        end
        // hold until the sequencer releases the request
        sync_io_pkg::W_FIN: if (!byte_req_i) state <= sync_io_pkg::W_IDLE;
        default: state <= sync_io_pkg::W_IDLE;
      endcase
    end
  end

  // bus accesses only start for a live request
  a_cyc_on_req: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $rose(wb_cyc_o) |-> (core_setup_req_i || byte_req_i));

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/sync_io_pkg.sv
hdl/sync_io_regs.sv
hdl/sync_io_sequencer.sv
hdl/wb_byte_writer.sv
hdl/ctrlport_to_sync_io.sv
tests/wb_i2c_core_model.sv
tests/tb_ctrlport_to_sync_io.sv

//--- tests/tb_ctrlport_to_sync_io.sv
`timescale 1ns/1ps
`default_nettype none

`include "sync_io_defs.svh"

module tb_ctrlport_to_sync_io;

  localparam int          ACK_TIMEOUT  = 8;
  localparam int          POLL_TIMEOUT = 500;
  localparam int          QUIET_CYCLES = 200;
  // core sees the user prescale divided by 5
  localparam logic [15:0] PRER_EXP     = `SYNC_IO_PRESCALE / 5;
  localparam logic [7:0]  ADDR_BYTE    = {`IO_EXP_SLAVE_ADDR, 1'b0};

  logic                      ctrlport_clk;
  logic                      ctrlport_rst;
  logic                      req_wr_i;
  logic                      req_rd_i;
  sync_io_pkg::ctrl_addr_t   req_addr_i;
  sync_io_pkg::ctrl_data_t   req_data_i;
  logic                      resp_ack_o;
  sync_io_pkg::ctrl_status_t resp_status_o;
  sync_io_pkg::ctrl_data_t   resp_data_o;
  logic                      wb_cyc;
  logic                      wb_we;
  sync_io_pkg::wb_addr_t     wb_adr;
  sync_io_pkg::wb_byte_t     wb_dat_w;
  logic                      wb_ack;
  sync_io_pkg::wb_byte_t     wb_dat_r;

  // expected core writes for the run under check
  logic [10:0]               exp_q [$];
  // switch values last written
  sync_io_pkg::sync_sel_t    sync_val [5];
  logic                      rfs_val;

  ctrlport_to_sync_io DUT (
    .ctrlport_clk  (ctrlport_clk),
    .ctrlport_rst  (ctrlport_rst),
    .req_wr_i      (req_wr_i),
    .req_rd_i      (req_rd_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .resp_ack_o    (resp_ack_o),
    .resp_status_o (resp_status_o),
    .resp_data_o   (resp_data_o),
    .wb_cyc_o      (wb_cyc),
    .wb_we_o       (wb_we),
    .wb_adr_o      (wb_adr),
    .wb_dat_o      (wb_dat_w),
    .wb_ack_i      (wb_ack),
    .wb_dat_i      (wb_dat_r)
  );

  wb_i2c_core_model core (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .wb_cyc_i     (wb_cyc),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_ack_o     (wb_ack),
    .wb_dat_o     (wb_dat_r)
  );

  always #5 ctrlport_clk = ~ctrlport_clk;

  // --------------------------------------------------
  // checking helpers
  // --------------------------------------------------
  task automatic report_error(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else
      report_error($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
                             $time, what, got, exp));
  endtask

  function automatic sync_io_pkg::ctrl_addr_t sync_offset(input int idx);
    return `SYNC_1_REG + 20'(4 * idx);
  endfunction

  // one txr write then one cr write per byte
  task automatic expect_byte(input logic [7:0] tx, input logic [7:0] cmd);
    exp_q.push_back({`WB_TXR, tx});
    exp_q.push_back({`WB_CR, cmd});
  endtask

  task automatic expect_setup_bytes();
    expect_byte(ADDR_BYTE, `CR_START_AND_WRITE);
    expect_byte(`IO_EXP_CONFIG0_REG, `CR_WRITE);
    expect_byte(8'h00, `CR_WRITE);
    expect_byte(8'h00, `CR_WRITE_AND_STOP);
  endtask

  task automatic check_log(input int start);
    int n;
    n = core.wr_log.size() - start;
    check_value("core write count", n, exp_q.size());
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("core write %0d {adr, dat}", i), core.wr_log[start + i], exp_q[i]);
    end
  endtask

  // --------------------------------------------------
  // controlport access
  // --------------------------------------------------
  // ack must come in the very next cycle
  task automatic ctrl_access(input logic wr, input sync_io_pkg::ctrl_addr_t offset,
                             input sync_io_pkg::ctrl_data_t data,
                             output sync_io_pkg::ctrl_status_t sts,
                             output sync_io_pkg::ctrl_data_t rdata);
    int cycles;
    @(posedge ctrlport_clk);
    req_wr_i   <= wr;
    req_rd_i   <= !wr;
    req_addr_i <= `SYNC_IO_BASE_ADDR + offset;
    req_data_i <= data;
    @(posedge ctrlport_clk);
    req_wr_i <= 1'b0;
    req_rd_i <= 1'b0;
    cycles = 0;
    @(negedge ctrlport_clk);
    while (!resp_ack_o && cycles < ACK_TIMEOUT) begin
      cycles++;
      @(negedge ctrlport_clk);
    end
    if (!resp_ack_o) begin
      report_error("timeout waiting for a ControlPort ack");
    end
    check_value("ack latency in cycles", cycles, 0);
    sts   = resp_status_o;
    rdata = resp_data_o;
  endtask

  task automatic ctrl_write(input sync_io_pkg::ctrl_addr_t offset,
                            input sync_io_pkg::ctrl_data_t data);
    sync_io_pkg::ctrl_status_t sts;
    sync_io_pkg::ctrl_data_t   rdata;
    ctrl_access(1'b1, offset, data, sts, rdata);
    check_value("write status", sts, `CTRL_STS_OKAY);
  endtask

  task automatic ctrl_read(input sync_io_pkg::ctrl_addr_t offset,
                           output sync_io_pkg::ctrl_status_t sts,
                           output sync_io_pkg::ctrl_data_t rdata);
    ctrl_access(1'b0, offset, '0, sts, rdata);
  endtask

  task automatic check_no_ack(input sync_io_pkg::ctrl_addr_t offset);
    int cycles;
    @(posedge ctrlport_clk);
    req_rd_i   <= 1'b1;
    req_addr_i <= `SYNC_IO_BASE_ADDR + offset;
    @(posedge ctrlport_clk);
    req_rd_i <= 1'b0;
    cycles = 0;
    while (cycles < 4) begin
      @(negedge ctrlport_clk);
      assert (!resp_ack_o) else report_error("an out-of-range read was acked");
      cycles++;
    end
  endtask

  // status bit reads 1 once the run is over
  task automatic wait_run_done(input sync_io_pkg::ctrl_addr_t offset);
    sync_io_pkg::ctrl_status_t sts;
    sync_io_pkg::ctrl_data_t   data;
    int                        polls;
    polls = 0;
    data  = '0;
    while (!data[0] && polls < POLL_TIMEOUT) begin
      ctrl_read(offset, sts, data);
      polls++;
    end
    if (!data[0]) begin
      report_error("timeout waiting for a sequencer run to finish");
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset();
    sync_io_pkg::ctrl_status_t sts;
    sync_io_pkg::ctrl_data_t   data;
    check_value("resp_ack_o after reset", resp_ack_o, 0);
    check_value("wb_cyc_o after reset", wb_cyc, 0);
    // five selects and the rfs bit
    for (int i = 0; i < 6; i++) begin
      ctrl_read(sync_offset(i), sts, data);
      check_value($sformatf("reset status at 0x%0h", sync_offset(i)), sts, `CTRL_STS_OKAY);
      check_value($sformatf("reset data at 0x%0h", sync_offset(i)), data, 0);
    end
    ctrl_read(`SETUP_REG, sts, data);
    check_value("setup done after reset", data, 1);
    ctrl_read(`CONFIG_IO_REG, sts, data);
    check_value("config done after reset", data, 1);
  endtask

  task automatic test_register_rw();
    sync_io_pkg::ctrl_status_t sts;
    sync_io_pkg::ctrl_data_t   data;
    logic [31:0]               val;
    for (int i = 0; i < 5; i++) begin
      val = $urandom;
      ctrl_write(sync_offset(i), val);
      sync_val[i] = val[2:0];
    end
    for (int i = 0; i < 5; i++) begin
      ctrl_read(sync_offset(i), sts, data);
      check_value($sformatf("sync %0d status", i + 1), sts, `CTRL_STS_OKAY);
      check_value($sformatf("sync %0d readback", i + 1), data, {29'b0, sync_val[i]});
    end
    val = $urandom;
    ctrl_write(`RFS_EN_REG, val);
    rfs_val = val[0];
    ctrl_read(`RFS_EN_REG, sts, data);
    check_value("rfs readback", data, val & 32'h1);
    // hole inside the window
    ctrl_read(`SYNC_2_REG + 20'h1, sts, data);
    check_value("unmapped read status", sts, `CTRL_STS_CMDERR);
    check_value("unmapped read data", data, 0);
    check_no_ack(20'(`SYNC_IO_NUM_ADDR));
  endtask

  task automatic test_setup_run();
    int start;
    start = core.wr_log.size();
    exp_q.delete();
    exp_q.push_back({`WB_PRER_LO, PRER_EXP[7:0]});
    exp_q.push_back({`WB_PRER_HI, PRER_EXP[15:8]});
    exp_q.push_back({`WB_CTR, `WB_CORE_EN});
    expect_setup_bytes();
    ctrl_write(`SETUP_REG, 1);
    wait_run_done(`SETUP_REG);
    check_log(start);
  endtask

  task automatic test_config_run();
    sync_io_pkg::io_word_t word;
    logic [31:0]           val;
    int                    start;
    for (int i = 0; i < 5; i++) begin
      val = $urandom;
      ctrl_write(sync_offset(i), val);
      sync_val[i] = val[2:0];
    end
    val = $urandom;
    ctrl_write(`RFS_EN_REG, val);
    rfs_val = val[0];
    // rfs on top, sync5 down to sync1
    word  = {rfs_val, sync_val[4], sync_val[3], sync_val[2], sync_val[1], sync_val[0]};
    start = core.wr_log.size();
    exp_q.delete();
    expect_byte(ADDR_BYTE, `CR_START_AND_WRITE);
    expect_byte(`IO_EXP_OUTPUT_PORT0_REG, `CR_WRITE);
    expect_byte(word[7:0], `CR_WRITE);
    expect_byte(word[15:8], `CR_WRITE_AND_STOP);
    ctrl_write(`CONFIG_IO_REG, 1);
    wait_run_done(`CONFIG_IO_REG);
    check_log(start);
  endtask

  // core stays enabled, so a second setup sends only the four bytes
  task automatic test_trigger_while_busy();
    int start;
    int quiet;
    start = core.wr_log.size();
    exp_q.delete();
    expect_setup_bytes();
    ctrl_write(`SETUP_REG, 1);
    ctrl_write(`CONFIG_IO_REG, 1);
    wait_run_done(`SETUP_REG);
    wait_run_done(`CONFIG_IO_REG);
    quiet = 0;
    while (!wb_cyc && quiet < QUIET_CYCLES) begin
      @(negedge ctrlport_clk);
      quiet++;
    end
    assert (!wb_cyc) else
      report_error("a Wishbone access started after the setup run ended");
    check_log(start);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    ctrlport_clk = 1'b0;
    ctrlport_rst = 1'b1;
    req_wr_i     = 1'b0;
    req_rd_i     = 1'b0;
    req_addr_i   = '0;
    req_data_i   = '0;
    void'($urandom(28583));
    repeat (5) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;
    @(negedge ctrlport_clk);
    test_reset();
    test_register_rw();
    test_setup_run();
    test_config_run();
    test_trigger_while_busy();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/wb_i2c_core_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "sync_io_defs.svh"

module wb_i2c_core_model (
  input  logic                  ctrlport_clk,
  input  logic                  ctrlport_rst,
  input  logic                  wb_cyc_i,
  input  logic                  wb_we_i,
  input  sync_io_pkg::wb_addr_t wb_adr_i,
  input  sync_io_pkg::wb_byte_t wb_dat_i,
  output logic                  wb_ack_o,
  output sync_io_pkg::wb_byte_t wb_dat_o
);

  // every acked write as {adr, dat}, oldest first
  logic [10:0] wr_log [$];

  logic        pending;
  int unsigned ack_wait;
  // transfer in progress flag, sr bit 1
  logic        tip;
  logic        tip_seen;
  int unsigned tip_left;

  initial begin
    wb_ack_o = 1'b0;
    wb_dat_o = '0;
  end

  always @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
      pending  <= 1'b0;
      ack_wait <= 0;
      tip      <= 1'b0;
      tip_seen <= 1'b0;
      tip_left <= 0;
    end else begin
      wb_ack_o <= 1'b0;
      // tip only counts down once a status read has seen it high
      if (tip && tip_seen) begin
        if (tip_left <= 1) begin
          tip <= 1'b0;
        end else begin
          tip_left <= tip_left - 1;
        end
      end
      // ack lands 1 to 3 cycles after cyc is seen
      if (wb_cyc_i && !wb_ack_o && !pending) begin
        pending  <= 1'b1;
        ack_wait <= $urandom_range(2, 0);
      end else if (pending) begin
        if (ack_wait == 0) begin
          pending  <= 1'b0;
          wb_ack_o <= 1'b1;
          if (wb_we_i) begin
            wr_log.push_back({wb_adr_i, wb_dat_i});
            // command write starts a byte transfer
            if (wb_adr_i == `WB_CR) begin
              tip      <= 1'b1;
              tip_seen <= 1'b0;
              tip_left <= $urandom_range(5, 2);
            end
          end else begin
            wb_dat_o <= {6'b0, tip, 1'b0};
            if (tip) begin
              tip_seen <= 1'b1;
            end
          end
        end else begin
          ack_wait <= ack_wait - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire
